// ==== rtl/mbox_ctrl.sv ====
/* Mailbox memory and lock control */

`timescale 1ns/1ns

module mbox_ctrl
    import soc_ifc_pkg::*;
(
    input  logic          soc_ifc_clk_cg,
    input  logic          cptra_noncore_rst_b,
    input  logic          req_dv_i,
    input  soc_ifc_req_t  req_i,
    output soc_ifc_data_t rdata_o,
    output logic          error_o,
    output logic          soc_data_avail_o,
    output logic          uc_data_avail_o
);

    soc_ifc_data_t mem [MBOX_DEPTH];
    logic          locked;
    requester_e    owner;
    requester_e    requester;
    logic          execute;
    logic          is_owner;
    logic          win_hit;
    mbox_idx_t     idx;
    logic          lock_take;
    logic          win_wr;
    logic          exec_wr;

    always_comb begin
        requester = req_i.soc_req ? REQ_SOC : REQ_UC;
        is_owner  = locked & (owner == requester);
        win_hit   = req_i.addr[SOC_IFC_ADDR_W-1:MBOX_IDX_W+2] ==
                    MBOX_WIN_BASE[SOC_IFC_ADDR_W-1:MBOX_IDX_W+2];
        idx       = req_i.addr[MBOX_IDX_W+1:2];
    end

    // Combinational read and write qualification
    always_comb begin
        rdata_o   = '0;
        error_o   = 1'b0;
        lock_take = 1'b0;
        win_wr    = 1'b0;
        exec_wr   = 1'b0;
        if (req_dv_i) begin
            if (win_hit) begin
                if (req_i.write) begin
                    win_wr  = is_owner;
                    error_o = ~is_owner;
                end else begin
                    rdata_o = mem[idx];
                end
            end else if (req_i.addr == MBOX_LOCK_ADDR) begin
                // Lock is taken by reading it while free
                if (req_i.write) begin
                    error_o = 1'b1;
                end else begin
                    rdata_o   = {{(SOC_IFC_DATA_W-1){1'b0}}, locked};
                    lock_take = ~locked;
                end
            end else if (req_i.addr == MBOX_EXECUTE_ADDR) begin
                if (req_i.write) begin
                    exec_wr = is_owner;
                    error_o = ~is_owner;
                end else begin
                    rdata_o = {{(SOC_IFC_DATA_W-1){1'b0}}, execute};
                end
            end else begin
                error_o = 1'b1;
            end
        end
    end

    always_ff @(posedge soc_ifc_clk_cg) begin
        if (win_wr) begin
            mem[idx] <= req_i.wdata;
        end
    end

    always_ff @(posedge soc_ifc_clk_cg or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            locked           <= 1'b0;
            owner            <= REQ_SOC;
            execute          <= 1'b0;
            soc_data_avail_o <= 1'b0;
            uc_data_avail_o  <= 1'b0;
        end else if (lock_take) begin
            locked <= 1'b1;
            owner  <= requester;
        end else if (exec_wr) begin
            execute          <= req_i.wdata[0];
            // Data goes to the side that does not own the lock
            soc_data_avail_o <= req_i.wdata[0] & (owner == REQ_UC);
            uc_data_avail_o  <= req_i.wdata[0] & (owner == REQ_SOC);
            if (!req_i.wdata[0]) begin
                locked <= 1'b0;
            end
        end
    end

    // A data-available flag lives only inside the lock of the other side
    assert property (@(posedge soc_ifc_clk_cg) disable iff (!cptra_noncore_rst_b)
        soc_data_avail_o |-> (locked && owner == REQ_UC));

    assert property (@(posedge soc_ifc_clk_cg) disable iff (!cptra_noncore_rst_b)
        uc_data_avail_o |-> (locked && owner == REQ_SOC));

endmodule

// ==== rtl/soc_ifc_arb.sv ====
/* Requester arbiter and address decode */

`timescale 1ns/1ns

module soc_ifc_arb
    import soc_ifc_pkg::*;
(
    input  logic          soc_ifc_clk_cg,
    input  logic          cptra_noncore_rst_b,
    input  logic          soc_req_dv_i,
    input  soc_ifc_req_t  soc_req_i,
    input  logic          uc_req_dv_i,
    input  soc_ifc_req_t  uc_req_i,
    input  soc_ifc_user_t valid_user_i,
    input  soc_ifc_data_t mbox_rdata_i,
    input  soc_ifc_data_t reg_rdata_i,
    input  logic          mbox_error_i,
    input  logic          reg_error_i,
    output logic          soc_req_hold_o,
    output logic          uc_req_hold_o,
    output soc_ifc_data_t soc_rdata_o,
    output soc_ifc_data_t uc_rdata_o,
    output logic          soc_error_o,
    output logic          uc_error_o,
    output logic          mbox_req_dv_o,
    output logic          reg_req_dv_o,
    output soc_ifc_req_t  tgt_req_o
);

    requester_e    last_grant;
    logic          soc_grant;
    logic          uc_grant;
    logic          any_grant;
    logic          mbox_hit;
    logic          reg_hit;
    logic          user_block;
    soc_ifc_data_t resp_rdata;
    logic          resp_error;

    // SoC wins unless the uC also asks and the SoC went last
    always_comb begin
        soc_grant = soc_req_dv_i & (~uc_req_dv_i | (last_grant == REQ_UC));
        uc_grant  = uc_req_dv_i & ~soc_grant;
        any_grant = soc_grant | uc_grant;
    end

    assign soc_req_hold_o = soc_req_dv_i & ~soc_grant;
    assign uc_req_hold_o  = uc_req_dv_i & ~uc_grant;
    assign tgt_req_o      = soc_grant ? soc_req_i : uc_req_i;

    // Region decode and SoC user filter on the mailbox
    always_comb begin
        mbox_hit   = tgt_req_o.addr[SOC_IFC_ADDR_W-1:REGION_LSB] ==
                     MBOX_WIN_BASE[SOC_IFC_ADDR_W-1:REGION_LSB];
        reg_hit    = tgt_req_o.addr[SOC_IFC_ADDR_W-1:REGION_LSB] ==
                     FLOW_STATUS_ADDR[SOC_IFC_ADDR_W-1:REGION_LSB];
        user_block = tgt_req_o.soc_req & (tgt_req_o.user != valid_user_i);
    end

    assign mbox_req_dv_o = any_grant & mbox_hit & ~user_block;
    assign reg_req_dv_o  = any_grant & reg_hit;

    // Blocked or unmapped requests answer with an error and zero data
    always_comb begin
        if (mbox_req_dv_o) begin
            resp_rdata = mbox_rdata_i;
            resp_error = mbox_error_i;
        end else if (reg_req_dv_o) begin
            resp_rdata = reg_rdata_i;
            resp_error = reg_error_i;
        end else begin
            resp_rdata = '0;
            resp_error = 1'b1;
        end
    end

    always_ff @(posedge soc_ifc_clk_cg or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            last_grant  <= REQ_UC;
            soc_error_o <= 1'b0;
            uc_error_o  <= 1'b0;
        end else begin
            if (any_grant) begin
                last_grant <= soc_grant ? REQ_SOC : REQ_UC;
            end
            if (soc_grant) begin
                soc_error_o <= resp_error;
            end
            if (uc_grant) begin
                uc_error_o <= resp_error;
            end
        end
    end

    always_ff @(posedge soc_ifc_clk_cg) begin
        if (soc_grant) begin
            soc_rdata_o <= resp_rdata;
        end
        if (uc_grant) begin
            uc_rdata_o <= resp_rdata;
        end
    end

    // A port that loses once wins in the next cycle
    assert property (@(posedge soc_ifc_clk_cg) disable iff (!cptra_noncore_rst_b)
        soc_req_hold_o |=> !soc_req_hold_o);

    assert property (@(posedge soc_ifc_clk_cg) disable iff (!cptra_noncore_rst_b)
        uc_req_hold_o |=> !uc_req_hold_o);

endmodule

// ==== rtl/soc_ifc_pkg.sv ====
/* SoC interface shared definitions */

package soc_ifc_pkg;

    // Bus widths
    localparam int SOC_IFC_ADDR_W = 16;
    localparam int SOC_IFC_DATA_W = 32;
    localparam int SOC_IFC_USER_W = 8;

    typedef logic [SOC_IFC_ADDR_W-1:0] soc_ifc_addr_t;
    typedef logic [SOC_IFC_DATA_W-1:0] soc_ifc_data_t;
    typedef logic [SOC_IFC_USER_W-1:0] soc_ifc_user_t;

    // Mailbox memory geometry
    localparam int MBOX_DEPTH = 64;
    localparam int MBOX_IDX_W = 6;

    typedef logic [MBOX_IDX_W-1:0] mbox_idx_t;

    // Address bits above this one select the target region
    localparam int REGION_LSB = 10;

    // Mailbox region
    localparam soc_ifc_addr_t MBOX_WIN_BASE     = 16'h0000;
    localparam soc_ifc_addr_t MBOX_LOCK_ADDR    = 16'h0200;
    localparam soc_ifc_addr_t MBOX_EXECUTE_ADDR = 16'h0204;

    // Register block region
    localparam soc_ifc_addr_t FLOW_STATUS_ADDR  = 16'h0400;
    localparam soc_ifc_addr_t GENERIC_OUT_ADDR  = 16'h0404;
    localparam soc_ifc_addr_t GENERIC_IN_ADDR   = 16'h0408;
    localparam soc_ifc_addr_t VALID_USER_ADDR   = 16'h040C;
    localparam soc_ifc_addr_t USER_LOCK_ADDR    = 16'h0410;
    localparam soc_ifc_addr_t INTR_STATUS_ADDR  = 16'h0414;
    localparam soc_ifc_addr_t INTR_ENABLE_ADDR  = 16'h0418;

    // User IDs
    localparam soc_ifc_user_t VALID_USER_RESET = 8'h01;
    localparam soc_ifc_user_t UC_USER_ID       = 8'hFF;

    // One request on the shared bus
    typedef struct packed {
        logic          write;
        soc_ifc_addr_t addr;
        soc_ifc_data_t wdata;
        soc_ifc_user_t user;
        logic          soc_req;
    } soc_ifc_req_t;

    // Requester identity for arbitration and mailbox ownership
    typedef enum logic {
        REQ_SOC = 1'b0,
        REQ_UC  = 1'b1
    } requester_e;

endpackage

// ==== rtl/soc_ifc_regs.sv ====
/* SoC interface register block */

`timescale 1ns/1ns

module soc_ifc_regs
    import soc_ifc_pkg::*;
(
    input  logic          soc_ifc_clk_cg,
    input  logic          cptra_noncore_rst_b,
    input  logic          req_dv_i,
    input  soc_ifc_req_t  req_i,
    input  soc_ifc_data_t generic_input_wires_i,
    input  logic          uc_data_avail_i,
    output soc_ifc_data_t rdata_o,
    output logic          error_o,
    output soc_ifc_user_t valid_user_o,
    output soc_ifc_data_t generic_output_wires_o,
    output logic          ready_for_fw_push_o,
    output logic          ready_for_runtime_o,
    output logic          notif_intr_o
);

    logic          wr;
    logic          user_lock;
    logic          intr_status;
    logic          intr_enable;
    logic          uc_avail_q;
    logic          avail_rise;

    assign wr = req_dv_i & req_i.write;

    // Address decode, read mux and access errors
    always_comb begin
        rdata_o = '0;
        error_o = 1'b0;
        case (req_i.addr)
            FLOW_STATUS_ADDR: begin
                rdata_o = {{(SOC_IFC_DATA_W-2){1'b0}}, ready_for_runtime_o,
                           ready_for_fw_push_o};
                error_o = req_i.write & req_i.soc_req;
            end
            GENERIC_OUT_ADDR: begin
                rdata_o = generic_output_wires_o;
                error_o = req_i.write & req_i.soc_req;
            end
            GENERIC_IN_ADDR: begin
                rdata_o = generic_input_wires_i;
                error_o = req_i.write;
            end
            VALID_USER_ADDR:  rdata_o = {{(SOC_IFC_DATA_W-SOC_IFC_USER_W){1'b0}}, valid_user_o};
            USER_LOCK_ADDR:   rdata_o = {{(SOC_IFC_DATA_W-1){1'b0}}, user_lock};
            INTR_STATUS_ADDR: rdata_o = {{(SOC_IFC_DATA_W-1){1'b0}}, intr_status};
            INTR_ENABLE_ADDR: rdata_o = {{(SOC_IFC_DATA_W-1){1'b0}}, intr_enable};
            default:          error_o = 1'b1;
        endcase
    end

    // Rising edge of the uC data-available flag
    assign avail_rise   = uc_data_avail_i & ~uc_avail_q;
    assign notif_intr_o = intr_status & intr_enable;

    always_ff @(posedge soc_ifc_clk_cg or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            ready_for_fw_push_o    <= 1'b0;
            ready_for_runtime_o    <= 1'b0;
            generic_output_wires_o <= '0;
            valid_user_o           <= VALID_USER_RESET;
            user_lock              <= 1'b0;
            intr_status            <= 1'b0;
            intr_enable            <= 1'b0;
            uc_avail_q             <= 1'b0;
        end else begin
            uc_avail_q <= uc_data_avail_i;
            if (wr && !error_o) begin
                case (req_i.addr)
                    FLOW_STATUS_ADDR: begin
                        ready_for_fw_push_o <= req_i.wdata[0];
                        ready_for_runtime_o <= req_i.wdata[1];
                    end
                    GENERIC_OUT_ADDR: generic_output_wires_o <= req_i.wdata;
                    VALID_USER_ADDR: begin
                        if (!user_lock) begin
                            valid_user_o <= req_i.wdata[SOC_IFC_USER_W-1:0];
                        end
                    end
                    // Sticky until reset
                    USER_LOCK_ADDR:   user_lock   <= user_lock | req_i.wdata[0];
                    INTR_ENABLE_ADDR: intr_enable <= req_i.wdata[0];
                    default: ;
                endcase
            end
            // New event wins over a clear in the same cycle
            if (avail_rise) begin
                intr_status <= 1'b1;
            end else if (wr && req_i.addr == INTR_STATUS_ADDR && req_i.wdata[0]) begin
                intr_status <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/soc_ifc_top.sv ====
/* SoC interface top level */

`timescale 1ns/1ns

module soc_ifc_top
    import soc_ifc_pkg::*;
(
    input  logic          soc_ifc_clk_cg,
    input  logic          cptra_noncore_rst_b,
    input  logic          soc_req_dv_i,
    input  soc_ifc_req_t  soc_req_i,
    output logic          soc_req_hold_o,
    output soc_ifc_data_t soc_rdata_o,
    output logic          soc_error_o,
    input  logic          uc_req_dv_i,
    input  soc_ifc_req_t  uc_req_i,
    output logic          uc_req_hold_o,
    output soc_ifc_data_t uc_rdata_o,
    output logic          uc_error_o,
    input  soc_ifc_data_t generic_input_wires_i,
    output soc_ifc_data_t generic_output_wires_o,
    output logic          ready_for_fw_push_o,
    output logic          ready_for_runtime_o,
    output logic          mailbox_data_avail_o,
    output logic          soc_ifc_notif_intr_o
);

    soc_ifc_req_t  soc_req;
    soc_ifc_req_t  uc_req;
    soc_ifc_req_t  tgt_req;
    logic          mbox_req_dv;
    logic          reg_req_dv;
    soc_ifc_data_t mbox_rdata;
    soc_ifc_data_t reg_rdata;
    logic          mbox_error;
    logic          reg_error;
    soc_ifc_user_t valid_user;
    logic          uc_data_avail;

    // Requester identity is fixed by the port, not by the requester
    always_comb begin
        soc_req         = soc_req_i;
        soc_req.soc_req = 1'b1;
        uc_req          = uc_req_i;
        uc_req.user     = UC_USER_ID;
        uc_req.soc_req  = 1'b0;
    end

    soc_ifc_arb i_soc_ifc_arb (
        .soc_ifc_clk_cg      (soc_ifc_clk_cg),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .soc_req_dv_i        (soc_req_dv_i),
        .soc_req_i           (soc_req),
        .uc_req_dv_i         (uc_req_dv_i),
        .uc_req_i            (uc_req),
        .valid_user_i        (valid_user),
        .mbox_rdata_i        (mbox_rdata),
        .reg_rdata_i         (reg_rdata),
        .mbox_error_i        (mbox_error),
        .reg_error_i         (reg_error),
        .soc_req_hold_o      (soc_req_hold_o),
        .uc_req_hold_o       (uc_req_hold_o),
        .soc_rdata_o         (soc_rdata_o),
        .uc_rdata_o          (uc_rdata_o),
        .soc_error_o         (soc_error_o),
        .uc_error_o          (uc_error_o),
        .mbox_req_dv_o       (mbox_req_dv),
        .reg_req_dv_o        (reg_req_dv),
        .tgt_req_o           (tgt_req)
    );

    mbox_ctrl i_mbox_ctrl (
        .soc_ifc_clk_cg      (soc_ifc_clk_cg),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_dv_i            (mbox_req_dv),
        .req_i               (tgt_req),
        .rdata_o             (mbox_rdata),
        .error_o             (mbox_error),
        .soc_data_avail_o    (mailbox_data_avail_o),
        .uc_data_avail_o     (uc_data_avail)
    );

    soc_ifc_regs i_soc_ifc_regs (
        .soc_ifc_clk_cg         (soc_ifc_clk_cg),
        .cptra_noncore_rst_b    (cptra_noncore_rst_b),
        .req_dv_i               (reg_req_dv),
        .req_i                  (tgt_req),
        .generic_input_wires_i  (generic_input_wires_i),
        .uc_data_avail_i        (uc_data_avail),
        .rdata_o                (reg_rdata),
        .error_o                (reg_error),
        .valid_user_o           (valid_user),
        .generic_output_wires_o (generic_output_wires_o),
        .ready_for_fw_push_o    (ready_for_fw_push_o),
        .ready_for_runtime_o    (ready_for_runtime_o),
        .notif_intr_o           (soc_ifc_notif_intr_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SoC interface testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_soc_ifc_top -f verilog.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_soc_ifc_top > sim.log 2>&1 || echo "simulation exited with nonzero status" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "nonzero status" sim.log && exit 1
exit 0

// ==== tb/soc_ifc_cases.txt ====
// port(0 SoC 1 uC 2 both) write addr wdata user exp_rdata exp_error exp_mbox_avail exp_intr
// Port 2 reads LFSR-picked window words on both ports; user and exp_error belong to the SoC
0 0 0200 00000000 01 00000000 0 0 0
1 0 0200 00000000 00 00000001 0 0 0
1 1 0000 DEAD0000 00 00000000 1 0 0
0 1 0000 1111A000 01 00000000 0 0 0
0 1 0004 2222B004 01 00000000 0 0 0
0 1 0008 3333C008 01 00000000 0 0 0
0 1 000C 4444D00C 01 00000000 0 0 0
1 1 0418 00000001 00 00000000 0 0 0
0 1 0204 00000001 01 00000000 0 0 0
1 0 0000 00000000 00 1111A000 0 0 1
1 0 0414 00000000 00 00000001 0 0 1
1 1 0414 00000001 00 00000001 0 0 0
0 0 0204 00000000 01 00000001 0 0 0
0 1 0204 00000000 01 00000000 0 0 0
1 0 0200 00000000 00 00000000 0 0 0
1 1 0204 00000001 00 00000000 0 1 0
1 1 0204 00000000 00 00000000 0 0 0
0 0 0004 00000000 22 00000000 1 0 0
1 1 040C 00000022 00 00000001 0 0 0
0 0 0004 00000000 22 2222B004 0 0 0
1 1 0410 00000001 00 00000000 0 0 0
1 1 040C 00000033 00 00000022 0 0 0
0 0 040C 00000000 22 00000022 0 0 0
1 1 0400 00000003 00 00000000 0 0 0
1 1 0404 CAFEF00D 00 00000000 0 0 0
0 0 0408 00000000 22 5A3C96E1 0 0 0
0 1 0404 00000001 22 CAFEF00D 1 0 0
0 0 041C 00000000 22 00000000 1 0 0
0 0 0800 00000000 22 00000000 1 0 0
2 0 0000 00000000 22 00000000 0 0 0
2 0 0000 00000000 22 00000000 0 0 0
2 0 0000 00000000 22 00000000 0 0 0
2 0 0000 00000000 01 00000000 1 0 0

// ==== tb/tb_soc_ifc_top.sv ====
/* SoC interface testbench */

`timescale 1ns/1ns

module tb_soc_ifc_top
    import soc_ifc_pkg::*;
();

    localparam int NUM_CASES      = 33;
    localparam int CASE_WORDS     = 9;
    localparam int TIMEOUT_CYCLES = NUM_CASES * 8 + 100;
    localparam soc_ifc_data_t GENERIC_IN_VAL = 32'h5A3C_96E1;

    logic          soc_ifc_clk_cg;
    logic          cptra_noncore_rst_b;
    logic          soc_dv;
    soc_ifc_req_t  soc_req;
    logic          soc_hold;
    soc_ifc_data_t soc_rdata;
    logic          soc_error;
    logic          uc_dv;
    soc_ifc_req_t  uc_req;
    logic          uc_hold;
    soc_ifc_data_t uc_rdata;
    logic          uc_error;
    soc_ifc_data_t gen_in;
    soc_ifc_data_t gen_out;
    logic          fw_push;
    logic          runtime;
    logic          mbox_avail;
    logic          notif_intr;

    logic [31:0]   cases_mem [NUM_CASES*CASE_WORDS];
    // Window words 0 to 3 as written by the cases
    soc_ifc_data_t win_model [4];
    logic [7:0]    lfsr;
    logic          last_was_uc;
    int            cur_case;
    int            cycle_count = 0;

    soc_ifc_top soc_ifc_top_i (
        .soc_ifc_clk_cg         (soc_ifc_clk_cg),
        .cptra_noncore_rst_b    (cptra_noncore_rst_b),
        .soc_req_dv_i           (soc_dv),
        .soc_req_i              (soc_req),
        .soc_req_hold_o         (soc_hold),
        .soc_rdata_o            (soc_rdata),
        .soc_error_o            (soc_error),
        .uc_req_dv_i            (uc_dv),
        .uc_req_i               (uc_req),
        .uc_req_hold_o          (uc_hold),
        .uc_rdata_o             (uc_rdata),
        .uc_error_o             (uc_error),
        .generic_input_wires_i  (gen_in),
        .generic_output_wires_o (gen_out),
        .ready_for_fw_push_o    (fw_push),
        .ready_for_runtime_o    (runtime),
        .mailbox_data_avail_o   (mbox_avail),
        .soc_ifc_notif_intr_o   (notif_intr)
    );

    initial begin
        soc_ifc_clk_cg = 1'b0;
        forever #2 soc_ifc_clk_cg = ~soc_ifc_clk_cg;
    end

    always @(posedge soc_ifc_clk_cg) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the case list did not finish", cycle_count);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s in case %0d: got 0x%h, expected 0x%h",
                     name, cur_case, got, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        logic [7:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 8'hB8;
        end
        return shifted;
    endfunction

    task automatic take_bits(input int count, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic check_flags(input int b);
        check_value("mailbox_data_avail_o", 32'(mbox_avail), cases_mem[b+7]);
        check_value("soc_ifc_notif_intr_o", 32'(notif_intr), cases_mem[b+8]);
    endtask

    task automatic run_single(input int b);
        logic         is_uc;
        logic         exp_err;
        soc_ifc_req_t req;
        is_uc       = cases_mem[b][0];
        exp_err     = cases_mem[b+6][0];
        req.write   = cases_mem[b+1][0];
        req.addr    = cases_mem[b+2][15:0];
        req.wdata   = cases_mem[b+3];
        req.user    = cases_mem[b+4][7:0];
        req.soc_req = !is_uc;
        if (is_uc) begin
            uc_req = req;
            uc_dv  = 1'b1;
        end else begin
            soc_req = req;
            soc_dv  = 1'b1;
        end
        // A held request stays on the bus until it wins
        #1;
        while (is_uc ? uc_hold : soc_hold) begin
            @(negedge soc_ifc_clk_cg);
            #1;
        end
        @(negedge soc_ifc_clk_cg);
        if (is_uc) begin
            check_value("uc_rdata_o", uc_rdata, cases_mem[b+5]);
            check_value("uc_error_o", 32'(uc_error), cases_mem[b+6]);
        end else begin
            check_value("soc_rdata_o", soc_rdata, cases_mem[b+5]);
            check_value("soc_error_o", 32'(soc_error), cases_mem[b+6]);
        end
        check_flags(b);
        soc_dv      = 1'b0;
        uc_dv       = 1'b0;
        last_was_uc = is_uc;
        if (req.write && !exp_err) begin
            if (req.addr[15:8] == 8'h00) begin
                win_model[req.addr[3:2]] = req.wdata;
            end else if (req.addr == GENERIC_OUT_ADDR) begin
                check_value("generic_output_wires_o", gen_out, req.wdata);
            end else if (req.addr == FLOW_STATUS_ADDR) begin
                check_value("ready_for_runtime_o/ready_for_fw_push_o",
                            32'({runtime, fw_push}), 32'(req.wdata[1:0]));
            end
        end
    endtask

    // Both ports read random window words in the same cycle
    task automatic run_contention(input int b);
        logic [7:0] bits;
        logic [1:0] soc_idx;
        logic [1:0] uc_idx;
        logic       soc_exp_err;
        logic       soc_acc;
        logic       uc_acc;
        logic       first;
        take_bits(2, bits);
        soc_idx = bits[1:0];
        take_bits(2, bits);
        uc_idx          = bits[1:0];
        soc_exp_err     = cases_mem[b+6][0];
        soc_req.write   = 1'b0;
        soc_req.addr    = MBOX_WIN_BASE + 16'({soc_idx, 2'b00});
        soc_req.wdata   = '0;
        soc_req.user    = cases_mem[b+4][7:0];
        soc_req.soc_req = 1'b1;
        uc_req.write    = 1'b0;
        uc_req.addr     = MBOX_WIN_BASE + 16'({uc_idx, 2'b00});
        uc_req.wdata    = '0;
        uc_req.user     = 8'h00;
        uc_req.soc_req  = 1'b0;
        soc_dv          = 1'b1;
        uc_dv           = 1'b1;
        first           = 1'b1;
        while (soc_dv || uc_dv) begin
            #1;
            check_value("soc_req_hold_o & uc_req_hold_o", 32'(soc_hold & uc_hold), 32'h0);
            if (first) begin
                // The port that did not win last goes first
                check_value("soc_req_hold_o", 32'(soc_hold), 32'(!last_was_uc));
                first = 1'b0;
            end
            soc_acc = soc_dv & !soc_hold;
            uc_acc  = uc_dv & !uc_hold;
            @(negedge soc_ifc_clk_cg);
            if (soc_acc) begin
                check_value("soc_rdata_o", soc_rdata, soc_exp_err ? 32'h0 : win_model[soc_idx]);
                check_value("soc_error_o", 32'(soc_error), 32'(soc_exp_err));
                soc_dv      = 1'b0;
                last_was_uc = 1'b0;
            end
            if (uc_acc) begin
                check_value("uc_rdata_o", uc_rdata, win_model[uc_idx]);
                check_value("uc_error_o", 32'(uc_error), 32'h0);
                uc_dv       = 1'b0;
                last_was_uc = 1'b1;
            end
        end
        check_flags(b);
    endtask

    initial begin
        cptra_noncore_rst_b = 1'b0;
        soc_dv              = 1'b0;
        soc_req             = '0;
        uc_dv               = 1'b0;
        uc_req              = '0;
        gen_in              = GENERIC_IN_VAL;
        lfsr                = 8'd95;
        last_was_uc         = 1'b1;
        cur_case            = -1;
        $readmemh("tb/soc_ifc_cases.txt", cases_mem);
        if ($isunknown(cases_mem[NUM_CASES*CASE_WORDS-1])) begin
            $display("case file tb/soc_ifc_cases.txt is missing or holds too few cases");
            $display("tests failed");
            $fatal(1);
        end
        repeat (2) @(posedge soc_ifc_clk_cg);
        @(negedge soc_ifc_clk_cg);
        // Outputs are quiet in reset
        check_value("soc_req_hold_o", 32'(soc_hold), 32'h0);
        check_value("uc_req_hold_o", 32'(uc_hold), 32'h0);
        check_value("soc_error_o", 32'(soc_error), 32'h0);
        check_value("uc_error_o", 32'(uc_error), 32'h0);
        check_value("mailbox_data_avail_o", 32'(mbox_avail), 32'h0);
        check_value("soc_ifc_notif_intr_o", 32'(notif_intr), 32'h0);
        check_value("ready_for_fw_push_o", 32'(fw_push), 32'h0);
        check_value("ready_for_runtime_o", 32'(runtime), 32'h0);
        cptra_noncore_rst_b = 1'b1;
        for (int n = 0; n < NUM_CASES; n++) begin
            cur_case = n;
            if (cases_mem[n*CASE_WORDS] == 32'h2) begin
                run_contention(n * CASE_WORDS);
            end else begin
                run_single(n * CASE_WORDS);
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/soc_ifc_pkg.sv
rtl/soc_ifc_arb.sv
rtl/mbox_ctrl.sv
rtl/soc_ifc_regs.sv
rtl/soc_ifc_top.sv
tb/tb_soc_ifc_top.sv
